/* Makefile */
# Verilator build and run for the rv32 core testbench

VERILATOR ?= verilator
TOP       ?= rv32_core_tb
FILELIST  ?= rv32_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, pass if the log holds the pass message"
	@echo "  clean  remove build output and the log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o sim
	./$(BUILD_DIR)/sim | tee $(LOG)
	grep -q "^Test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/program_trace.txt */
# test <name> <hold seed>, inst <word> <rd to check or 0> <expected rd>, run <cycles>
# mem <byte addr> <expected word>, dbg <reg> <write data> <expected read>, reuse <test>
test alu_ops 0
inst 00500093 1 00000005
inst ffd00113 2 fffffffd
inst 002081b3 3 00000002
inst 40208233 4 00000008
inst 401152b3 5 ffffffff
inst 0020b333 6 00000001
inst 0f00c393 7 000000f5
inst 00409413 8 00000050
inst 40115493 9 fffffffe
inst 00112533 10 00000001
run 24
test upper_imm 0
inst 123450b7 1 12345000
inst 00001117 2 00001004
run 10
test load_store 0
inst deadc0b7 0 00000000
inst eef08093 1 deadbeef
inst 04000113 2 00000040
inst 00112423 0 00000000
inst 00812183 3 deadbeef
run 16
mem 00000048 deadbeef 00000000
test branches 0
inst 00100093 1 00000001
inst 00200113 2 00000002
inst 00000313 0 00000000
inst 00208463 0 00000000
inst 00130313 0 00000000
inst 00209463 0 00000000
inst 01030313 0 00000000
inst 00114463 0 00000000
inst 00230313 0 00000000
inst 00115463 0 00000000
inst 01030313 0 00000000
inst 008003ef 7 00000030
inst 01030313 0 00000000
inst 04000493 9 00000040
inst 00048467 8 0000003c
inst 01030313 0 00000000
inst 00430313 6 00000007
run 32
test debug_port 0
run 4
dbg 00000005 cafef00d cafef00d
dbg 00000000 12345678 00000000
test alu_hold 0000958c
reuse alu_ops
run 60

/* bench/rv32_core_tb.sv */
// rv32 core testbench
// trace-driven programs, memory models and debug-port register checks
`include "core_settings.svh"

module rv32_core_tb
    import core_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int K_INST = 0;
    localparam int K_MEM  = 1;
    localparam int K_DBG  = 2;

    logic               clk;
    logic               gen_rst_n;
    logic               test_rst_n;
    logic [`XLEN-1:0]   pc;
    logic [`XLEN-1:0]   inst_i;
    dmem_req_t          dmem;
    logic [`XLEN-1:0]   dmem_rdata_i;
    logic               bus_hold_i;
    logic               dbg_halt_i;
    logic               dbg_we_i;
    logic [`REG_AW-1:0] dbg_addr_i;
    logic [`XLEN-1:0]   dbg_wdata_i;
    logic [`XLEN-1:0]   dbg_rdata_o;

    logic [31:0] imem [0:255];
    logic [31:0] dmem_arr [0:255];
    logic [31:0] rd_word_q;

    // parsed trace
    string       test_name [$];
    logic [31:0] test_seed [$];
    int          test_run [$];
    int          test_src [$];
    int          rec_test [$];
    int          rec_kind [$];
    logic [31:0] rec_a [$];
    logic [31:0] rec_b [$];
    logic [31:0] rec_c [$];

    int checks;
    int errors;
    int test_err;
    int failed_tests;

    tb_clock_gen u_tb_clock_gen (
        .clk_o   (clk),
        .rst_n_o (gen_rst_n)
    );

    rv32_core u_rv32_core (
        .clk_i        (clk),
        .arst_n_i     (gen_rst_n & test_rst_n),
        .pc_o         (pc),
        .inst_i       (inst_i),
        .dmem_o       (dmem),
        .dmem_rdata_i (dmem_rdata_i),
        .bus_hold_i   (bus_hold_i),
        .dbg_halt_i   (dbg_halt_i),
        .dbg_we_i     (dbg_we_i),
        .dbg_addr_i   (dbg_addr_i),
        .dbg_wdata_i  (dbg_wdata_i),
        .dbg_rdata_o  (dbg_rdata_o)
    );

    // ------------------------------------------------------------------------
    // memory models, requests sampled at the rising edge
    // ------------------------------------------------------------------------
    always @(posedge clk) begin
        if (dmem.req && dmem.we) begin
            dmem_arr[dmem.addr[9:2]] <= dmem.wdata;
        end
        if (dmem.req && !dmem.we) begin
            rd_word_q <= dmem_arr[dmem.addr[9:2]];
        end
    end

    always @(negedge clk) begin
        inst_i       <= imem[pc[9:2]];
        dmem_rdata_i <= rd_word_q;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] v;
        v = x ^ (x << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            test_err++;
            $display("error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic read_trace();
        int          fd;
        int          n;
        int          cycles;
        string       line;
        string       kind;
        string       name;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        fd = $fopen("bench/program_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open the trace file bench/program_trace.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n < 2 || line[0] == "#") begin
                    continue;
                end
                n = $sscanf(line, "%s", kind);
                if (kind == "test") begin
                    n = $sscanf(line, "%s %s %h", kind, name, a);
                    test_name.push_back(name);
                    test_seed.push_back(a);
                    test_run.push_back(0);
                    test_src.push_back(test_name.size() - 1);
                end else if (kind == "reuse") begin
                    n = $sscanf(line, "%s %s", kind, name);
                    foreach (test_name[i]) begin
                        if (test_name[i] == name) begin
                            test_src[test_src.size() - 1] = i;
                        end
                    end
                end else if (kind == "run") begin
                    n = $sscanf(line, "%s %d", kind, cycles);
                    test_run[test_run.size() - 1] = cycles;
                end else begin
                    n = $sscanf(line, "%s %h %h %h", kind, a, b, c);
                    if (kind == "inst") begin
                        n = $sscanf(line, "%s %h %d %h", kind, a, b, c);
                    end
                    rec_test.push_back(test_name.size() - 1);
                    rec_kind.push_back(kind == "inst" ? K_INST : (kind == "mem" ? K_MEM : K_DBG));
                    rec_a.push_back(a);
                    rec_b.push_back(b);
                    rec_c.push_back(c);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic reset_and_load(input int src);
        int idx;
        @(negedge clk);
        test_rst_n = 1'b0;
        bus_hold_i = 1'b0;
        dbg_halt_i = 1'b0;
        dbg_we_i   = 1'b0;
        for (int i = 0; i < 256; i++) begin
            imem[i]     = `NOP_INST;
            dmem_arr[i] = 32'hd000_0000 | (i << 2);
        end
        idx = 0;
        foreach (rec_test[r]) begin
            if (rec_test[r] == src && rec_kind[r] == K_INST) begin
                imem[idx] = rec_a[r];
                idx++;
            end
        end
        repeat (4) @(negedge clk);
        test_rst_n = 1'b1;
    endtask

    task automatic run_test(input int t);
        logic [31:0] rnd;
        rnd      = 32'h958c;
        test_err = 0;
        reset_and_load(test_src[t]);
        // reset state, before the first edge after release
        check_value($sformatf("%s reset pc", test_name[t]), `RESET_PC, pc);
        check_value($sformatf("%s reset dmem req", test_name[t]), 32'h0,
                    {30'b0, dmem.req, dmem.we});
        for (int cyc = 0; cyc < test_run[t]; cyc++) begin
            @(negedge clk);
            bus_hold_i = 1'b0;
            if (test_seed[t] != 0) begin
                rnd        = xorshift(rnd);
                bus_hold_i = (rnd[1:0] == 2'b00);
            end
        end
        @(negedge clk);
        bus_hold_i = 1'b0;
        dbg_halt_i = 1'b1;
        foreach (rec_test[r]) begin
            if (rec_test[r] == t && rec_kind[r] == K_DBG) begin
                @(negedge clk);
                dbg_we_i    = 1'b1;
                dbg_addr_i  = rec_a[r][4:0];
                dbg_wdata_i = rec_b[r];
                @(negedge clk);
                dbg_we_i = 1'b0;
                @(posedge clk);
                check_value($sformatf("%s dbg x%0d", test_name[t], rec_a[r]),
                            rec_c[r], dbg_rdata_o);
            end else if (rec_test[r] == test_src[t] && rec_kind[r] == K_INST
                         && rec_b[r] != 0) begin
                @(negedge clk);
                dbg_addr_i = rec_b[r][4:0];
                @(posedge clk);
                check_value($sformatf("%s x%0d", test_name[t], rec_b[r]),
                            rec_c[r], dbg_rdata_o);
            end else if (rec_test[r] == t && rec_kind[r] == K_MEM) begin
                check_value($sformatf("%s mem %h", test_name[t], rec_a[r]),
                            rec_b[r], dmem_arr[rec_a[r][9:2]]);
            end
        end
        if (test_err == 0) begin
            $display("test %s ok", test_name[t]);
        end else begin
            failed_tests++;
            $display("test %s failed with %0d mismatches", test_name[t], test_err);
        end
    endtask

    initial begin
        int limit;
        test_rst_n   = 1'b0;
        inst_i       = `NOP_INST;
        dmem_rdata_i = '0;
        bus_hold_i   = 1'b0;
        dbg_halt_i   = 1'b0;
        dbg_we_i     = 1'b0;
        dbg_addr_i   = '0;
        dbg_wdata_i  = '0;
        checks       = 0;
        errors       = 0;
        failed_tests = 0;
        read_trace();

        // watchdog sized from the run lengths and the number of checks
        limit = 200 + 20 * test_name.size() + 4 * rec_test.size();
        foreach (test_run[t]) begin
            limit += test_run[t];
        end
        fork
            begin
                #(limit * 8);
                $display("the run timed out after %0d cycles", limit);
                $display("Test failed");
                $finish;
            end
        join_none

        @(posedge gen_rst_n);
        foreach (test_name[t]) begin
            run_test(t);
        end
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 test_name.size(), failed_tests, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* bench/tb_clock_gen.sv */
// testbench clock and power-on reset
// 8 ns clock, reset held low for 4 cycles
module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (4) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

/* rv32_core.f */
+incdir+verilog
verilog/rv_isa_pkg.sv
verilog/core_pkg.sv
verilog/fetch_unit.sv
verilog/decoder.sv
verilog/exec_unit.sv
verilog/regs_file.sv
verilog/rv32_core.sv
bench/tb_clock_gen.sv
bench/rv32_core_tb.sv

/* verilog/core_pkg.sv */
// core micro-architecture types
// control and request bundles passed between the core blocks
`include "core_settings.svh"

package core_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC_A_RS1,
        SRC_A_PC,
        SRC_A_ZERO
    } src_a_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_PC4,
        WB_LOAD
    } wb_sel_e;

    typedef struct packed {
        alu_op_e            alu_op;
        src_a_e             src_a;
        logic               src_b_imm;
        wb_sel_e            wb_sel;
        logic               rd_we;
        logic [`REG_AW-1:0] rd;
        logic [`REG_AW-1:0] rs1;
        logic [`REG_AW-1:0] rs2;
        logic               is_branch;
        logic [2:0]         br_f3;
        logic               is_jal;
        logic               is_jalr;
        logic               mem_rd;
        logic               mem_wr;
    } dec_ctrl_t;

    typedef struct packed {
        logic               we;
        logic [`REG_AW-1:0] addr;
        logic [`XLEN-1:0]   data;
    } rf_wr_t;

    typedef struct packed {
        logic             req;
        logic             we;
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] wdata;
    } dmem_req_t;

endpackage

/* verilog/core_settings.svh */
// core settings
// widths, reset fetch address and the pipeline bubble word
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// data path and address width
`define XLEN 32

// register index width, 32 architectural registers
`define REG_AW 5

// first fetch address after reset
`define RESET_PC 32'h0000_0000

// addi x0, x0, 0
`define NOP_INST 32'h0000_0013

`endif

/* verilog/decoder.sv */
// instruction decoder
// opcode and funct decode into the control bundle, plus immediate generation
`include "core_settings.svh"

module decoder
    import rv_isa_pkg::*;
    import core_pkg::*;
(
    input  rv_inst_u         inst_i,
    output dec_ctrl_t        ctrl_o,
    output logic [`XLEN-1:0] imm_o
);

    // alt selects sub and sra
    function automatic alu_op_e alu_sel(input alu_f3_e f3, input logic alt);
        alu_op_e op;
        case (f3)
            F3_ADD:  op = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:  op = ALU_SLL;
            F3_SLT:  op = ALU_SLT;
            F3_SLTU: op = ALU_SLTU;
            F3_XOR:  op = ALU_XOR;
            F3_SR:   op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:   op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    dec_ctrl_t ctrl;
    logic      imm_shift_alt;

    // only shifts use funct7 in the immediate form
    assign imm_shift_alt = (inst_i.i.funct3 == F3_SR) && inst_i.r.funct7[5];

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = ALU_ADD;
        ctrl.src_a  = SRC_A_RS1;
        ctrl.wb_sel = WB_ALU;
        ctrl.rd     = inst_i.r.rd;
        ctrl.rs1    = inst_i.r.rs1;
        ctrl.rs2    = inst_i.r.rs2;
        ctrl.br_f3  = inst_i.b.funct3;
        imm_o       = '0;

        case (inst_i.r.opcode)
            OP_LUI, OP_AUIPC: begin
                ctrl.src_a     = (inst_i.u.opcode == OP_LUI) ? SRC_A_ZERO : SRC_A_PC;
                ctrl.src_b_imm = 1'b1;
                ctrl.rd_we     = 1'b1;
                imm_o          = {inst_i.u.imm, 12'b0};
            end
            OP_JAL: begin
                ctrl.is_jal = 1'b1;
                ctrl.wb_sel = WB_PC4;
                ctrl.rd_we  = 1'b1;
                imm_o = {{11{inst_i.j.imm20}}, inst_i.j.imm20, inst_i.j.imm19_12,
                         inst_i.j.imm11, inst_i.j.imm10_1, 1'b0};
            end
            OP_JALR: begin
                ctrl.is_jalr = 1'b1;
                ctrl.wb_sel  = WB_PC4;
                ctrl.rd_we   = 1'b1;
                imm_o        = {{20{inst_i.i.imm[11]}}, inst_i.i.imm};
            end
            OP_BRANCH: begin
                ctrl.is_branch = 1'b1;
                imm_o = {{19{inst_i.b.imm12}}, inst_i.b.imm12, inst_i.b.imm11,
                         inst_i.b.imm10_5, inst_i.b.imm4_1, 1'b0};
            end
            OP_LOAD: begin
                ctrl.mem_rd    = 1'b1;
                ctrl.wb_sel    = WB_LOAD;
                ctrl.src_b_imm = 1'b1;
                ctrl.rd_we     = 1'b1;
                imm_o          = {{20{inst_i.i.imm[11]}}, inst_i.i.imm};
            end
            OP_STORE: begin
                ctrl.mem_wr    = 1'b1;
                ctrl.src_b_imm = 1'b1;
                imm_o = {{20{inst_i.s.imm_hi[6]}}, inst_i.s.imm_hi, inst_i.s.imm_lo};
            end
            OP_IMM: begin
                ctrl.alu_op    = alu_sel(inst_i.i.funct3, imm_shift_alt);
                ctrl.src_b_imm = 1'b1;
                ctrl.rd_we     = 1'b1;
                imm_o          = {{20{inst_i.i.imm[11]}}, inst_i.i.imm};
            end
            OP_REG: begin
                ctrl.alu_op = alu_sel(inst_i.r.funct3, inst_i.r.funct7[5]);
                ctrl.rd_we  = 1'b1;
            end
            // unknown opcode runs as a bubble
            default: ctrl.rd_we = 1'b0;
        endcase

        // x0 is never a write target
        if (ctrl.rd == '0) begin
            ctrl.rd_we = 1'b0;
        end
    end

    assign ctrl_o = ctrl;

endmodule

/* verilog/exec_unit.sv */
// execute stage
// alu, branch resolution, data memory access and register write-back
`include "core_settings.svh"

module exec_unit
    import rv_isa_pkg::*;
    import core_pkg::*;
(
    input  logic             clk_i,
    input  logic             arst_n_i,
    input  logic             freeze_i,
    input  logic [`XLEN-1:0] pc_i,
    input  dec_ctrl_t        ctrl_i,
    input  logic [`XLEN-1:0] imm_i,
    input  logic [`XLEN-1:0] rs1_data_i,
    input  logic [`XLEN-1:0] rs2_data_i,
    input  logic [`XLEN-1:0] dmem_rdata_i,
    output rf_wr_t           rf_wr_o,
    output dmem_req_t        dmem_o,
    output logic             redirect_o,
    output logic [`XLEN-1:0] target_o,
    output logic             stall_o
);

    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] alu_res;
    logic [`XLEN-1:0] jump_sum;
    logic             br_taken;
    logic             load_first;
    logic             load_pend_q;

    // ------------------------------------------------------------------------
    // alu
    // ------------------------------------------------------------------------
    always_comb begin
        case (ctrl_i.src_a)
            SRC_A_PC:   op_a = pc_i;
            SRC_A_ZERO: op_a = '0;
            default:    op_a = rs1_data_i;
        endcase
        op_b = ctrl_i.src_b_imm ? imm_i : rs2_data_i;

        case (ctrl_i.alu_op)
            ALU_SUB:  alu_res = op_a - op_b;
            ALU_SLL:  alu_res = op_a << op_b[4:0];
            ALU_SRL:  alu_res = op_a >> op_b[4:0];
            ALU_SRA:  alu_res = $unsigned($signed(op_a) >>> op_b[4:0]);
            ALU_SLT:  alu_res = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_res = {{(`XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:  alu_res = op_a ^ op_b;
            ALU_OR:   alu_res = op_a | op_b;
            ALU_AND:  alu_res = op_a & op_b;
            default:  alu_res = op_a + op_b;
        endcase
    end

    // ------------------------------------------------------------------------
    // branches and jumps
    // ------------------------------------------------------------------------
    always_comb begin
        case (ctrl_i.br_f3)
            F3_BEQ:  br_taken = rs1_data_i == rs2_data_i;
            F3_BNE:  br_taken = rs1_data_i != rs2_data_i;
            F3_BLT:  br_taken = $signed(rs1_data_i) < $signed(rs2_data_i);
            F3_BGE:  br_taken = $signed(rs1_data_i) >= $signed(rs2_data_i);
            default: br_taken = 1'b0;
        endcase
    end

    assign jump_sum   = (ctrl_i.is_jalr ? rs1_data_i : pc_i) + imm_i;
    assign target_o   = {jump_sum[`XLEN-1:1], 1'b0};
    assign redirect_o = ctrl_i.is_jal || ctrl_i.is_jalr || (ctrl_i.is_branch && br_taken);

    // ------------------------------------------------------------------------
    // data memory, loads take two cycles
    // ------------------------------------------------------------------------
    assign load_first = ctrl_i.mem_rd && !load_pend_q && !freeze_i;
    assign stall_o    = load_first;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            load_pend_q <= 1'b0;
        end else if (!freeze_i) begin
            load_pend_q <= load_first;
        end
    end

    always_comb begin
        dmem_o.req   = load_first || (ctrl_i.mem_wr && !freeze_i);
        dmem_o.we    = ctrl_i.mem_wr && !freeze_i;
        dmem_o.addr  = alu_res;
        dmem_o.wdata = rs2_data_i;
    end

    // write-back, a load writes in its second cycle
    always_comb begin
        rf_wr_o.we   = ctrl_i.rd_we && !freeze_i && (!ctrl_i.mem_rd || load_pend_q);
        rf_wr_o.addr = ctrl_i.rd;
        case (ctrl_i.wb_sel)
            WB_PC4:  rf_wr_o.data = pc_i + `XLEN'd4;
            WB_LOAD: rf_wr_o.data = dmem_rdata_i;
            default: rf_wr_o.data = alu_res;
        endcase
    end

    // a load keeps its slot for the completion cycle
    a_load_held: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        load_pend_q |-> ctrl_i.mem_rd
    );

endmodule

/* verilog/fetch_unit.sv */
// fetch stage
// program counter and the fetch/execute register, with stall and flush
`include "core_settings.svh"

module fetch_unit
    import rv_isa_pkg::*;
(
    input  logic             clk_i,
    input  logic             arst_n_i,
    input  logic             freeze_i,
    input  logic             stall_i,
    input  logic             redirect_i,
    input  logic [`XLEN-1:0] target_i,
    input  logic [`XLEN-1:0] inst_i,
    output logic [`XLEN-1:0] pc_o,
    output logic [`XLEN-1:0] id_pc_o,
    output rv_inst_u         id_inst_o
);

    logic [`XLEN-1:0] pc_q;
    logic [`XLEN-1:0] id_pc_q;
    rv_inst_u         id_inst_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q      <= `RESET_PC;
            id_pc_q   <= `RESET_PC;
            id_inst_q <= `NOP_INST;
        end else if (!freeze_i) begin
            if (redirect_i) begin
                // wrong-path word dropped, one bubble
                pc_q      <= target_i;
                id_inst_q <= `NOP_INST;
            end else if (!stall_i) begin
                pc_q      <= pc_q + `XLEN'd4;
                id_pc_q   <= pc_q;
                id_inst_q <= inst_i;
            end
        end
    end

    assign pc_o      = pc_q;
    assign id_pc_o   = id_pc_q;
    assign id_inst_o = id_inst_q;

    // redirect targets come from execute and must keep fetch aligned
    a_pc_aligned: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        pc_q[1:0] == 2'b00
    );

endmodule

/* verilog/regs_file.sv */
// integer register file
// 31 registers, three read ports, one write port shared by core and debug
`include "core_settings.svh"

module regs_file
    import core_pkg::*;
(
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  rf_wr_t             core_wr_i,
    input  rf_wr_t             dbg_wr_i,
    input  logic [`REG_AW-1:0] rs1_addr_i,
    input  logic [`REG_AW-1:0] rs2_addr_i,
    input  logic [`REG_AW-1:0] dbg_addr_i,
    output logic [`XLEN-1:0]   rs1_data_o,
    output logic [`XLEN-1:0]   rs2_data_o,
    output logic [`XLEN-1:0]   dbg_rdata_o
);

    // x0 has no storage
    logic [`XLEN-1:0] regs_q [1:31];
    rf_wr_t           wr_sel;

    function automatic logic [`XLEN-1:0] rd_port(input logic [`REG_AW-1:0] addr);
        logic [`XLEN-1:0] val;
        val = '0;
        if (addr != '0) begin
            val = regs_q[addr];
        end
        return val;
    endfunction

    // fixed priority, debug first
    assign wr_sel = dbg_wr_i.we ? dbg_wr_i : core_wr_i;

    always_ff @(posedge clk_i) begin
        if (wr_sel.we && wr_sel.addr != '0) begin
            regs_q[wr_sel.addr] <= wr_sel.data;
        end
    end

    always_comb begin
        rs1_data_o  = rd_port(rs1_addr_i);
        rs2_data_o  = rd_port(rs2_addr_i);
        dbg_rdata_o = rd_port(dbg_addr_i);
    end

    // debug writes only arrive while halt freezes the core write
    a_no_wr_conflict: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        !(core_wr_i.we && dbg_wr_i.we)
    );

    // decode never targets x0 from the core side
    a_core_no_x0: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        core_wr_i.we |-> core_wr_i.addr != '0
    );

endmodule

/* verilog/rv32_core.sv */
// rv32i two-stage core
// fetch and execute with a shared register file and a debug register port
`include "core_settings.svh"

module rv32_core
    import rv_isa_pkg::*;
    import core_pkg::*;
(
    input  logic               clk_i,
    input  logic               arst_n_i,
    output logic [`XLEN-1:0]   pc_o,
    input  logic [`XLEN-1:0]   inst_i,
    output dmem_req_t          dmem_o,
    input  logic [`XLEN-1:0]   dmem_rdata_i,
    input  logic               bus_hold_i,
    input  logic               dbg_halt_i,
    input  logic               dbg_we_i,
    input  logic [`REG_AW-1:0] dbg_addr_i,
    input  logic [`XLEN-1:0]   dbg_wdata_i,
    output logic [`XLEN-1:0]   dbg_rdata_o
);

    logic             freeze;
    logic             stall;
    logic             redirect;
    logic [`XLEN-1:0] target;
    logic [`XLEN-1:0] id_pc;
    rv_inst_u         id_inst;
    dec_ctrl_t        ctrl;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;
    rf_wr_t           core_wr;
    rf_wr_t           dbg_wr;

    // whole-core freeze
    assign freeze = bus_hold_i | dbg_halt_i;
    assign dbg_wr = '{we: dbg_we_i, addr: dbg_addr_i, data: dbg_wdata_i};

    fetch_unit u_fetch_unit (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .freeze_i   (freeze),
        .stall_i    (stall),
        .redirect_i (redirect),
        .target_i   (target),
        .inst_i     (inst_i),
        .pc_o       (pc_o),
        .id_pc_o    (id_pc),
        .id_inst_o  (id_inst)
    );

    decoder u_decoder (
        .inst_i (id_inst),
        .ctrl_o (ctrl),
        .imm_o  (imm)
    );

    exec_unit u_exec_unit (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .freeze_i     (freeze),
        .pc_i         (id_pc),
        .ctrl_i       (ctrl),
        .imm_i        (imm),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .dmem_rdata_i (dmem_rdata_i),
        .rf_wr_o      (core_wr),
        .dmem_o       (dmem_o),
        .redirect_o   (redirect),
        .target_o     (target),
        .stall_o      (stall)
    );

    regs_file u_regs_file (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .core_wr_i   (core_wr),
        .dbg_wr_i    (dbg_wr),
        .rs1_addr_i  (ctrl.rs1),
        .rs2_addr_i  (ctrl.rs2),
        .dbg_addr_i  (dbg_addr_i),
        .rs1_data_o  (rs1_data),
        .rs2_data_o  (rs2_data),
        .dbg_rdata_o (dbg_rdata_o)
    );

endmodule

/* verilog/rv_isa_pkg.sv */
// rv32i isa definitions
// instruction formats, major opcodes and funct3 encodings
`include "core_settings.svh"

package rv_isa_pkg;

    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_e;

    typedef enum logic [2:0] {
        F3_ADD  = 3'b000,
        F3_SLL  = 3'b001,
        F3_SLT  = 3'b010,
        F3_SLTU = 3'b011,
        F3_XOR  = 3'b100,
        F3_SR   = 3'b101,
        F3_OR   = 3'b110,
        F3_AND  = 3'b111
    } alu_f3_e;

    // branch conditions share the funct3 field
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [2:0] F3_BLT = 3'b100;
    localparam logic [2:0] F3_BGE = 3'b101;

    // ------------------------------------------------------------------------
    // encoding formats, msb first
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic [6:0]         funct7;
        logic [`REG_AW-1:0] rs2;
        logic [`REG_AW-1:0] rs1;
        alu_f3_e            funct3;
        logic [`REG_AW-1:0] rd;
        opcode_e            opcode;
    } inst_r_t;

    typedef struct packed {
        logic [11:0]        imm;
        logic [`REG_AW-1:0] rs1;
        alu_f3_e            funct3;
        logic [`REG_AW-1:0] rd;
        opcode_e            opcode;
    } inst_i_t;

    typedef struct packed {
        logic [6:0]         imm_hi;
        logic [`REG_AW-1:0] rs2;
        logic [`REG_AW-1:0] rs1;
        logic [2:0]         funct3;
        logic [4:0]         imm_lo;
        opcode_e            opcode;
    } inst_s_t;

    typedef struct packed {
        logic               imm12;
        logic [5:0]         imm10_5;
        logic [`REG_AW-1:0] rs2;
        logic [`REG_AW-1:0] rs1;
        logic [2:0]         funct3;
        logic [3:0]         imm4_1;
        logic               imm11;
        opcode_e            opcode;
    } inst_b_t;

    typedef struct packed {
        logic [19:0]        imm;
        logic [`REG_AW-1:0] rd;
        opcode_e            opcode;
    } inst_u_t;

    typedef struct packed {
        logic               imm20;
        logic [9:0]         imm10_1;
        logic               imm11;
        logic [7:0]         imm19_12;
        logic [`REG_AW-1:0] rd;
        opcode_e            opcode;
    } inst_j_t;

    // one fetched word, viewed through each format
    typedef union packed {
        inst_r_t r;
        inst_i_t i;
        inst_s_t s;
        inst_b_t b;
        inst_u_t u;
        inst_j_t j;
    } rv_inst_u;

endpackage
